//--- src/io_bus_pkg.sv
package io_bus_pkg;

   // Bus widths of the CPU I/O port.
   localparam int ADDR_W = 16;
   localparam int DATA_W = 8;

   // Timer register map.
   localparam logic [ADDR_W-1:0] DIV_ADDR  = 16'hFF04; // Divider, read only.
   localparam logic [ADDR_W-1:0] TIMA_ADDR = 16'hFF05; // Counter.
   localparam logic [ADDR_W-1:0] TMA_ADDR  = 16'hFF06; // Reload value.
   localparam logic [ADDR_W-1:0] TAC_ADDR  = 16'hFF07; // Control.
   localparam logic [ADDR_W-1:0] IF_ADDR   = 16'hFF0F; // Interrupt flags.

   // Register access modes.
   localparam logic [1:0] MODE_RW = 2'b00;
   localparam logic [1:0] MODE_WO = 2'b01;
   localparam logic [1:0] MODE_RO = 2'b10;

   // Prescaler width. DIV shows its upper eight bits.
   localparam int PRESCALE_W = 12;

   // TAC layout.
   localparam int TAC_EN_BIT = 2;        // Timer enable.
   localparam int TAC_SEL_W  = 2;        // Clock select field in bits 1:0.
   localparam int TICK_BIT_LO = 3;       // Select code 0 watches prescaler bit 3.

   // IF bit raised on counter overflow.
   localparam int TIMER_IRQ_BIT = 2;

   // Registers that feed the read data network.
   localparam int NUM_REGS = 5;

   // Internal bus from the bridge to every register.
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic              we;    // One-cycle write strobe.
      logic              re;    // One-cycle read strobe.
      logic [DATA_W-1:0] wdata;
   } io_bus_t;

   // Wishbone classic request from the master.
   typedef struct packed {
      logic              cyc;
      logic              stb;
      logic              we;
      logic [ADDR_W-1:0] adr;
      logic [DATA_W-1:0] dat;
   } wb_req_t;

   // Wishbone classic response to the master.
   typedef struct packed {
      logic              ack;
      logic [DATA_W-1:0] dat;
   } wb_rsp_t;

endpackage

//--- src/io_register.sv
module io_register import io_bus_pkg::*; #(
   parameter logic [ADDR_W-1:0] REG_ADDR      = '0,      // Address the register answers to.
   parameter logic [DATA_W-1:0] RST_VAL       = '0,      // Value after reset or clear on read.
   parameter bit                FORWARD       = 1'b0,    // Return module write data on a read.
   parameter bit                RESET_ON_READ = 1'b0,    // Clear after a bus read.
   parameter logic [1:0]        MODE          = MODE_RW  // RW, WO or RO.
) (
   input  logic              I_CLK,
   input  logic              I_SYNC_RESET,

   // CPU side.
   input  io_bus_t           bus,
   output logic [DATA_W-1:0] bus_rdata,   // Zero unless this register is being read.

   // Module side.
   input  logic [DATA_W-1:0] data_wr,
   input  logic              wr_en,
   output logic [DATA_W-1:0] value,
   output logic              bus_wait     // CPU write to this register in this cycle.
);

   logic [DATA_W-1:0] value_q;
   logic [DATA_W-1:0] rd_val;
   logic              addr_hit;
   logic              bus_wr;
   logic              bus_rd;

   assign addr_hit = (bus.addr == REG_ADDR);

   // A read only register ignores CPU writes.
   assign bus_wr = addr_hit & bus.we & (MODE != MODE_RO);

   // A write only register never drives read data.
   assign bus_rd = addr_hit & bus.re & (MODE != MODE_WO);

   // The module side must back off while the CPU writes.
   assign bus_wait = bus_wr;

   assign value = value_q;

   // Forwarding shows the value about to be written by the module.
   assign rd_val = (FORWARD && wr_en) ? data_wr : value_q;

   // Each register drives zero when idle so the bridge can OR all of them.
   assign bus_rdata = bus_rd ? rd_val : '0;

   always_ff @(posedge I_CLK) begin
      if (I_SYNC_RESET) begin
         value_q <= RST_VAL;
      end else if (RESET_ON_READ && bus_rd) begin
         value_q <= RST_VAL;                    // Read clears, even over a module write.
      end else if (bus_wr) begin
         value_q <= bus.wdata;                  // CPU write wins.
      end else if (wr_en) begin
         value_q <= data_wr;                    // Module update.
      end
   end

endmodule

//--- src/wb_io_bridge.sv
module wb_io_bridge import io_bus_pkg::*; (
   input  logic              I_CLK,
   input  logic              I_SYNC_RESET,

   // Wishbone classic slave port.
   input  wb_req_t           wb_req,
   output wb_rsp_t           wb_rsp,

   // Internal register bus.
   output io_bus_t           bus,
   input  logic [DATA_W-1:0] rdata [NUM_REGS]
);

   logic              busy_q;     // Request already strobed, waiting for stb to drop.
   logic              strobe;     // First cycle of a new request.
   logic              ack_q;
   logic [DATA_W-1:0] rd_or;
   logic [DATA_W-1:0] rdat_q;

   // Only the first cycle of a held request reaches the registers.
   assign strobe = wb_req.cyc & wb_req.stb & ~busy_q;

   always_comb begin
      bus.addr  = wb_req.adr;
      bus.wdata = wb_req.dat;
      bus.we    = strobe & wb_req.we;
      bus.re    = strobe & ~wb_req.we;
   end

   // Idle registers return zero, so a plain OR selects the addressed one.
   always_comb begin
      rd_or = '0;
      for (int i = 0; i < NUM_REGS; i++) begin
         rd_or = rd_or | rdata[i];
      end
   end

   // Busy follows the request and clears once the master drops stb.
   always_ff @(posedge I_CLK) begin
      if (I_SYNC_RESET) begin
         busy_q <= 1'b0;
         ack_q  <= 1'b0;
      end else begin
         busy_q <= wb_req.cyc & wb_req.stb;
         ack_q  <= strobe;                    // One ack per request.
      end
   end

   // Read data is sampled in the strobe cycle and held until the next one.
   always_ff @(posedge I_CLK) begin
      if (strobe) begin
         rdat_q <= rd_or;                     // Zero for a write.
      end
   end

   assign wb_rsp.ack = ack_q;
   assign wb_rsp.dat = rdat_q;

endmodule

//--- src/timer_unit.sv
module timer_unit import io_bus_pkg::*; (
   input  logic              I_CLK,
   input  logic              I_SYNC_RESET,

   // Current register contents.
   input  logic [DATA_W-1:0] tima,
   input  logic [DATA_W-1:0] tma,
   input  logic [DATA_W-1:0] tac,
   input  logic [DATA_W-1:0] irq_flags,

   // CPU write in progress on TIMA or IF.
   input  logic              tima_wait,
   input  logic              if_wait,

   // Module write ports.
   output logic [DATA_W-1:0] div_data,
   output logic              div_wr_en,
   output logic [DATA_W-1:0] tima_data,
   output logic              tima_wr_en,
   output logic [DATA_W-1:0] if_data,
   output logic              if_wr_en
);

   logic [PRESCALE_W-1:0] prescale_q;     // Free-running divider.
   logic [PRESCALE_W-1:0] prescale_nxt;
   logic                  run_q;          // Low for the first cycle out of reset.
   logic                  sel_bit;        // Prescaler bit picked by TAC.
   logic                  sel_prev_q;     // Last cycle's sel_bit for edge detection.
   logic                  tick;
   logic                  overflow;
   logic                  irq_req;
   logic                  irq_pend_q;     // Flag set held off by a CPU write to IF.

   assign prescale_nxt = prescale_q + PRESCALE_W'(1);

   always_ff @(posedge I_CLK) begin
      if (I_SYNC_RESET) begin
         prescale_q <= '0;
         run_q      <= 1'b0;
      end else begin
         prescale_q <= prescale_nxt;
         run_q      <= 1'b1;
      end
   end

   // DIV gets the upper prescaler bits of the next count, so it
   // tracks the prescaler exactly. Missing the first write is harmless
   // since bit 4 cannot have flipped yet.
   assign div_data  = prescale_nxt[PRESCALE_W-1 -: DATA_W];
   assign div_wr_en = run_q;

   // Select codes 0..3 watch bits 3, 5, 7, 9 for periods 16 to 1024.
   assign sel_bit = prescale_q[TICK_BIT_LO + 2 * tac[TAC_SEL_W-1:0]];

   always_ff @(posedge I_CLK) begin
      if (I_SYNC_RESET) begin
         sel_prev_q <= 1'b0;
      end else begin
         sel_prev_q <= sel_bit;
      end
   end

   // Count on a falling edge of the watched bit.
   assign tick     = tac[TAC_EN_BIT] & sel_prev_q & ~sel_bit;
   assign overflow = tick & (&tima);      // Tick at FF reloads.

   // A CPU write to TIMA drops the tick, reload included.
   assign tima_wr_en = tick & ~tima_wait;
   assign tima_data  = overflow ? tma : tima + DATA_W'(1);

   // New overflow or one left over from a blocked cycle.
   assign irq_req = (overflow & ~tima_wait) | irq_pend_q;

   assign if_wr_en = irq_req & ~if_wait;
   assign if_data  = irq_flags | (DATA_W'(1) << TIMER_IRQ_BIT);   // Keep other flags.

   always_ff @(posedge I_CLK) begin
      if (I_SYNC_RESET) begin
         irq_pend_q <= 1'b0;
      end else begin
         irq_pend_q <= irq_req & if_wait;  // Retry next cycle.
      end
   end

endmodule

//--- src/io_timer_top.sv
module io_timer_top import io_bus_pkg::*; (
   input  logic    I_CLK,
   input  logic    I_SYNC_RESET,
   input  wb_req_t wb_req,
   output wb_rsp_t wb_rsp
);

   io_bus_t           bus;
   logic [DATA_W-1:0] reg_rdata [NUM_REGS];   // One slot per register.

   // Register values seen by the timer.
   logic [DATA_W-1:0] tima_value;
   logic [DATA_W-1:0] tma_value;
   logic [DATA_W-1:0] tac_value;
   logic [DATA_W-1:0] if_value;

   // Timer write ports.
   logic [DATA_W-1:0] div_data;
   logic              div_wr_en;
   logic [DATA_W-1:0] tima_data;
   logic              tima_wr_en;
   logic [DATA_W-1:0] if_data;
   logic              if_wr_en;
   logic              tima_wait;
   logic              if_wait;

   wb_io_bridge wb_io_bridge_inst (
      .I_CLK        (I_CLK),
      .I_SYNC_RESET (I_SYNC_RESET),
      .wb_req       (wb_req),
      .wb_rsp       (wb_rsp),
      .bus          (bus),
      .rdata        (reg_rdata)
   );

   // DIV only changes from the timer side.
   io_register #(.REG_ADDR(DIV_ADDR), .MODE(MODE_RO)) div_reg (
      .I_CLK (I_CLK), .I_SYNC_RESET (I_SYNC_RESET), .bus (bus), .bus_rdata (reg_rdata[0]),
      .data_wr (div_data), .wr_en (div_wr_en), .value (), .bus_wait ()
   );

   io_register #(.REG_ADDR(TIMA_ADDR)) tima_reg (
      .I_CLK (I_CLK), .I_SYNC_RESET (I_SYNC_RESET), .bus (bus), .bus_rdata (reg_rdata[1]),
      .data_wr (tima_data), .wr_en (tima_wr_en), .value (tima_value), .bus_wait (tima_wait)
   );

   // TMA and TAC are CPU owned, so their module ports stay idle.
   io_register #(.REG_ADDR(TMA_ADDR)) tma_reg (
      .I_CLK (I_CLK), .I_SYNC_RESET (I_SYNC_RESET), .bus (bus), .bus_rdata (reg_rdata[2]),
      .data_wr ('0), .wr_en (1'b0), .value (tma_value), .bus_wait ()
   );

   io_register #(.REG_ADDR(TAC_ADDR)) tac_reg (
      .I_CLK (I_CLK), .I_SYNC_RESET (I_SYNC_RESET), .bus (bus), .bus_rdata (reg_rdata[3]),
      .data_wr ('0), .wr_en (1'b0), .value (tac_value), .bus_wait ()
   );

   // IF returns a flag set in flight and clears when read.
   io_register #(.REG_ADDR(IF_ADDR), .FORWARD(1'b1), .RESET_ON_READ(1'b1)) if_reg (
      .I_CLK (I_CLK), .I_SYNC_RESET (I_SYNC_RESET), .bus (bus), .bus_rdata (reg_rdata[4]),
      .data_wr (if_data), .wr_en (if_wr_en), .value (if_value), .bus_wait (if_wait)
   );

   timer_unit timer_unit_inst (
      .I_CLK        (I_CLK),
      .I_SYNC_RESET (I_SYNC_RESET),
      .tima         (tima_value),
      .tma          (tma_value),
      .tac          (tac_value),
      .irq_flags    (if_value),
      .tima_wait    (tima_wait),
      .if_wait      (if_wait),
      .div_data     (div_data),
      .div_wr_en    (div_wr_en),
      .tima_data    (tima_data),
      .tima_wr_en   (tima_wr_en),
      .if_data      (if_data),
      .if_wr_en     (if_wr_en)
   );

endmodule

//--- tb/io_timer_model.svh
`ifndef IO_TIMER_MODEL_SVH
`define IO_TIMER_MODEL_SVH

// Cycle model of the timer block.
logic [PRESCALE_W-1:0] m_prescale;   // Cycles since reset release.
logic                  m_sel_prev;   // Watched prescaler bit, last cycle.
logic                  m_irq_pend;   // Flag set waiting for a free IF cycle.
logic [DATA_W-1:0]     m_tima;
logic [DATA_W-1:0]     m_tma;
logic [DATA_W-1:0]     m_tac;
logic [DATA_W-1:0]     m_if;
logic                  m_busy;       // Request seen, stb not yet dropped.
logic                  m_ack;        // Expected ack in this cycle.
logic [DATA_W-1:0]     m_rdat;       // Expected response data.

// Advances the model by one rising edge with the request seen in that cycle.
function automatic void model_step(input logic rst, input wb_req_t req);
   logic              strobe;
   logic              wr;
   logic              rd;
   logic              tima_hit;
   logic              if_hit;
   logic              tick;
   logic              ovf;
   logic              irq;
   logic              if_set;
   logic [DATA_W-1:0] rd_val;
   int                sel;
   if (rst) begin
      m_prescale = '0;
      m_sel_prev = 1'b0;
      m_irq_pend = 1'b0;
      m_tima     = '0;
      m_tma      = '0;
      m_tac      = '0;
      m_if       = '0;
      m_busy     = 1'b0;
      m_ack      = 1'b0;
      m_rdat     = '0;
      return;
   end
   strobe   = req.cyc & req.stb & ~m_busy;           // First cycle of a request.
   wr       = strobe & req.we;
   rd       = strobe & ~req.we;
   tima_hit = wr && (req.adr == TIMA_ADDR);
   if_hit   = wr && (req.adr == IF_ADDR);
   sel      = 3 + 2 * int'(m_tac[TAC_SEL_W-1:0]);    // Periods 16, 64, 256, 1024.
   tick     = m_tac[TAC_EN_BIT] && m_sel_prev && !m_prescale[sel];
   ovf      = tick && (m_tima == 8'hFF);
   irq      = (ovf && !tima_hit) || m_irq_pend;      // Dropped with the TIMA tick.
   if_set   = irq && !if_hit;                        // CPU write to IF wins.
   case (req.adr)
      DIV_ADDR:  rd_val = m_prescale[PRESCALE_W-1 -: DATA_W];
      TIMA_ADDR: rd_val = m_tima;
      TMA_ADDR:  rd_val = m_tma;
      TAC_ADDR:  rd_val = m_tac;
      IF_ADDR:   rd_val = if_set ? (m_if | (DATA_W'(1) << TIMER_IRQ_BIT)) : m_if;
      default:   rd_val = '0;
   endcase
   if (!rd) rd_val = '0;                             // Writes return zero.
   if (tima_hit) m_tima = req.dat;
   else if (tick) m_tima = ovf ? m_tma : m_tima + DATA_W'(1);
   if (rd && req.adr == IF_ADDR) m_if = '0;          // Cleared by the read.
   else if (if_hit) m_if = req.dat;
   else if (if_set) m_if = m_if | (DATA_W'(1) << TIMER_IRQ_BIT);
   if (wr && req.adr == TMA_ADDR) m_tma = req.dat;
   if (wr && req.adr == TAC_ADDR) m_tac = req.dat;
   m_irq_pend = irq && if_hit;
   m_sel_prev = m_prescale[sel];
   m_prescale = m_prescale + PRESCALE_W'(1);
   m_busy     = req.cyc & req.stb;
   m_ack      = strobe;
   if (strobe) m_rdat = rd_val;
endfunction

`endif

//--- tb/tb_io_timer.sv
module tb_io_timer import io_bus_pkg::*; ();

   localparam int ACK_TIMEOUT = 20;   // Cycles to wait for ack.
   localparam int POLL_LIMIT  = 40;   // IF reads before giving up.
   localparam int ALIGN_LIMIT = 64;   // Cycles to wait for a tick cycle.
   localparam logic [DATA_W-1:0] TAC_RUN16 = DATA_W'(1) << TAC_EN_BIT;    // Select 0.
   localparam logic [DATA_W-1:0] IRQ_MASK  = DATA_W'(1) << TIMER_IRQ_BIT;

   logic    I_CLK;
   logic    I_SYNC_RESET;
   wb_req_t wb_req;
   wb_rsp_t wb_rsp;

   integer  seed;
   int      errors = 0;
   int      checks = 0;
   int      reqs   = 0;   // Requests issued.
   int      acks   = 0;   // Acks seen.

   `include "io_timer_model.svh"

   io_timer_top io_timer_top_inst (
      .I_CLK        (I_CLK),
      .I_SYNC_RESET (I_SYNC_RESET),
      .wb_req       (wb_req),
      .wb_rsp       (wb_rsp)
   );

   initial begin
      I_CLK = 1'b0;
      forever #50 I_CLK = ~I_CLK;
   end

   always @(posedge I_CLK) begin
      model_step(I_SYNC_RESET, wb_req);      // Same inputs as the DUT.
   end

   // Every response is compared at the falling edge where outputs are stable.
   always @(negedge I_CLK) begin
      checks++;
      if (wb_rsp.ack === 1'b1) acks++;
      assert (wb_rsp.ack === m_ack) else begin
         $display("Fail at %0t: wb_rsp.ack expected %b, actual %b", $time, m_ack, wb_rsp.ack);
         errors++;
      end
      if (m_ack) begin
         checks++;
         assert (wb_rsp.dat === m_rdat) else begin
            $display("Fail at %0t: wb_rsp.dat expected %h, actual %h", $time, m_rdat,
                     wb_rsp.dat);
            errors++;
         end
      end
   end

   task automatic expect_eq(input string name, input logic [DATA_W-1:0] exp_val,
                            input logic [DATA_W-1:0] act_val);
      checks++;
      assert (act_val === exp_val) else begin
         $display("Fail at %0t: %s expected %h, actual %h", $time, name, exp_val, act_val);
         errors++;
      end
   endtask

   // Called at a falling edge. Returns one idle cycle after the ack.
   task automatic bus_access(input logic we, input logic [ADDR_W-1:0] adr,
                             input logic [DATA_W-1:0] dat, output logic [DATA_W-1:0] rdat);
      int n;
      n           = 0;
      rdat        = '0;
      reqs++;
      wb_req.cyc  = 1'b1;
      wb_req.stb  = 1'b1;
      wb_req.we   = we;
      wb_req.adr  = adr;
      wb_req.dat  = dat;
      do begin
         @(negedge I_CLK);
         n++;
      end while (wb_rsp.ack !== 1'b1 && n < ACK_TIMEOUT);
      if (wb_rsp.ack === 1'b1) rdat = wb_rsp.dat;
      else begin
         $display("Timeout: no ack for access to %h within %0d cycles", adr, ACK_TIMEOUT);
         errors++;
      end
      wb_req.cyc = 1'b0;
      wb_req.stb = 1'b0;
      wb_req.we  = 1'b0;
      @(negedge I_CLK);                          // Stb low for one cycle.
   endtask

   task automatic wb_write(input logic [ADDR_W-1:0] adr, input logic [DATA_W-1:0] dat);
      logic [DATA_W-1:0] unused;
      bus_access(1'b1, adr, dat, unused);
   endtask

   task automatic wb_read(input logic [ADDR_W-1:0] adr, output logic [DATA_W-1:0] dat);
      bus_access(1'b0, adr, '0, dat);
   endtask

   // Waits for a cycle in which a period 16 tick lands, TIMA at FF or not.
   task automatic align_to_tick(input logic at_ff);
      logic found;
      found = 1'b0;
      for (int n = 0; n < ALIGN_LIMIT && !found; n++) begin
         if (m_prescale[3:0] == 4'h0 && (m_tima == 8'hFF) == at_ff) found = 1'b1;
         else @(negedge I_CLK);
      end
      if (!found) begin
         $display("Timeout: no counter tick seen within %0d cycles", ALIGN_LIMIT);
         errors++;
      end
   endtask

   task automatic finish_test(input int num, input string name, input int err_start);
      if (errors == err_start) $display("Test %0d (%s) passed", num, name);
      else $display("Test %0d (%s) failed with %0d errors", num, name, errors - err_start);
   endtask

   initial begin
      logic [DATA_W-1:0] rd;
      logic [DATA_W-1:0] v_tma;
      logic [DATA_W-1:0] v_tac;
      int                err_start;
      int                reqs_start;
      int                acks_start;
      int                n;
      seed         = 92;
      wb_req       = '0;
      I_SYNC_RESET = 1'b1;
      repeat (5) @(negedge I_CLK);
      I_SYNC_RESET = 1'b0;

      // 1. Reset values, no ack while idle.
      err_start = errors;
      repeat (4) begin
         @(negedge I_CLK);
         checks++;
         assert (wb_rsp.ack === 1'b0) else begin
            $display("Fail at %0t: wb_rsp.ack expected 0, actual %b", $time, wb_rsp.ack);
            errors++;
         end
      end
      wb_read(TIMA_ADDR, rd);
      expect_eq("TIMA", 8'h00, rd);
      wb_read(TMA_ADDR, rd);
      expect_eq("TMA", 8'h00, rd);
      wb_read(TAC_ADDR, rd);
      expect_eq("TAC", 8'h00, rd);
      wb_read(IF_ADDR, rd);
      expect_eq("IF", 8'h00, rd);
      finish_test(1, "reset values", err_start);

      // 2. Random readback, one ack per request.
      err_start  = errors;
      reqs_start = reqs;
      acks_start = acks;
      for (int i = 0; i < 8; i++) begin
         v_tma = DATA_W'($random(seed));
         v_tac = DATA_W'($random(seed));
         wb_write(TMA_ADDR, v_tma);
         wb_write(TAC_ADDR, v_tac);
         wb_read(TMA_ADDR, rd);
         expect_eq("TMA", v_tma, rd);
         wb_read(TAC_ADDR, rd);
         expect_eq("TAC", v_tac, rd);
      end
      checks++;
      assert (acks - acks_start == reqs - reqs_start) else begin
         $display("Fail at %0t: ack count expected %0d, actual %0d", $time,
                  reqs - reqs_start, acks - acks_start);
         errors++;
      end
      finish_test(2, "TMA and TAC readback", err_start);

      // 3. DIV follows the prescaler and ignores writes.
      err_start = errors;
      for (int i = 0; i < 4; i++) begin
         n = int'($random(seed) & 63);
         repeat (n) @(negedge I_CLK);
         wb_read(DIV_ADDR, rd);                  // Read at a random prescaler count.
      end
      wb_read(DIV_ADDR, rd);
      wb_write(DIV_ADDR, ~rd);                   // Read only register.
      wb_read(DIV_ADDR, rd);                     // Still the prescaler count.
      finish_test(3, "DIV", err_start);

      // 4. Overflow sets the flag, read clears it.
      err_start = errors;
      v_tma     = DATA_W'($random(seed)) & 8'h7F;   // Reload far from FF.
      wb_write(TAC_ADDR, 8'h00);
      wb_write(TMA_ADDR, v_tma);
      wb_write(TIMA_ADDR, 8'hFE);
      wb_read(IF_ADDR, rd);                      // Drop old flags.
      wb_write(TAC_ADDR, TAC_RUN16);
      n  = 0;
      rd = '0;
      while (!rd[TIMER_IRQ_BIT] && n < POLL_LIMIT) begin
         wb_read(IF_ADDR, rd);
         n++;
      end
      if (!rd[TIMER_IRQ_BIT]) begin
         $display("Timeout: IF timer flag not set after %0d reads", POLL_LIMIT);
         errors++;
      end
      wb_read(IF_ADDR, rd);
      expect_eq("IF", 8'h00, rd);
      wb_read(TIMA_ADDR, rd);
      checks++;
      assert (DATA_W'(rd - v_tma) <= DATA_W'(1)) else begin
         $display("Fail at %0t: TIMA expected %h or next, actual %h", $time, v_tma, rd);
         errors++;
      end
      finish_test(4, "overflow and IF clear", err_start);

      // 5. CPU writes win over the timer.
      err_start = errors;
      align_to_tick(1'b0);
      wb_write(TIMA_ADDR, 8'h40);                // Tick dropped.
      wb_read(TIMA_ADDR, rd);
      expect_eq("TIMA", 8'h40, rd);
      wb_write(TIMA_ADDR, 8'hFF);
      align_to_tick(1'b1);
      wb_write(TIMA_ADDR, 8'h20);                // Reload and flag dropped.
      wb_read(IF_ADDR, rd);
      expect_eq("IF", 8'h00, rd);
      wb_read(TIMA_ADDR, rd);
      expect_eq("TIMA", 8'h20, rd);
      wb_write(TIMA_ADDR, 8'hFF);
      align_to_tick(1'b1);
      wb_write(IF_ADDR, 8'h01);                  // Flag set lands one cycle later.
      wb_read(IF_ADDR, rd);
      expect_eq("IF", 8'h01 | IRQ_MASK, rd);
      wb_read(TIMA_ADDR, rd);
      expect_eq("TIMA", v_tma, rd);              // Reloaded from TMA.
      finish_test(5, "CPU write priority", err_start);

      $display("Checks: %0d run, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

//--- vlog.f
+incdir+tb
src/io_bus_pkg.sv
src/io_register.sv
src/wb_io_bridge.sv
src/timer_unit.sv
src/io_timer_top.sv
tb/tb_io_timer.sv

//--- Makefile
# Verilator build and run of the timer testbench.

VERILATOR ?= verilator
TOP       ?= tb_io_timer
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Simulation finished: PASS

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard src/*.sv tb/*.sv tb/*.svh)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   Build with Verilator and run the simulation"
	@echo "  clean  Remove the build directory"
	@echo "  help   Show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
